// ==== bench/rf_cappuccino_tb.sv ====
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_cappuccino_tb;

   localparam int FIELDS   = 17;
   localparam int MAX_RECS = 64;
   localparam int SPR_WAIT = 20;

   logic [31:0] vec_mem [0:FIELDS*MAX_RECS-1];
   integer      seed;

   logic               clk;
   logic               rst;
   logic               padv_decode_i;
   logic               padv_ctrl_i;
   logic               pipeline_flush_i;
   logic               decode_valid_i;
   logic               fetch_rf_adr_valid_i;
   rf_pkg::reg_adr_t   fetch_rfb_adr_i;
   rf_pkg::reg_adr_t   decode_rfa_adr_i;
   rf_pkg::reg_adr_t   decode_rfb_adr_i;
   rf_pkg::reg_adr_t   execute_rfd_adr_i;
   rf_pkg::reg_adr_t   ctrl_rfd_adr_i;
   rf_pkg::reg_adr_t   wb_rfd_adr_i;
   logic               execute_rf_wb_i;
   logic               ctrl_rf_wb_i;
   logic               wb_rf_wb_i;
   rf_pkg::operand_t   ctrl_alu_result_i;
   rf_pkg::operand_t   result_i;
   logic               spr_stb_i;
   logic               spr_we_i;
   spr_pkg::spr_adr_u  spr_adr_i;
   rf_pkg::operand_t   spr_dat_i;
   logic               spr_ack_o;
   rf_pkg::operand_t   spr_dat_o;
   rf_pkg::operand_t   decode_rfb_o;
   rf_pkg::operand_t   execute_rfa_o;
   rf_pkg::operand_t   execute_rfb_o;

   rf_cappuccino dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_operand(input string name, input rf_pkg::operand_t act,
                                input rf_pkg::operand_t exp);
      if (act !== exp) begin
         stop_with_failure($sformatf("Error: %s actual %h expected %h", name, act, exp));
      end
   endtask

   task automatic check_spr(input spr_pkg::spr_adr_u adr, input rf_pkg::operand_t exp);
      if (spr_dat_o !== exp) begin
         stop_with_failure($sformatf("Error: spr_dat_o at spr address %h actual %h expected %h",
                                     adr, spr_dat_o, exp));
      end
   endtask

   function automatic spr_pkg::spr_adr_u gpr_spr_adr(input rf_pkg::reg_adr_t num);
      spr_pkg::spr_adr_u adr;
      adr             = '0;
      adr.gpr.page    = `SPR_GPR_PAGE;
      adr.gpr.gpr_num = num;
      return adr;
   endfunction

   task automatic drive_pipeline(input int base, input logic [7:0] flags);
      padv_decode_i        = flags[7];
      padv_ctrl_i          = flags[6];
      pipeline_flush_i     = flags[5];
      decode_valid_i       = flags[4];
      fetch_rf_adr_valid_i = flags[3];
      execute_rf_wb_i      = flags[2];
      ctrl_rf_wb_i         = flags[1];
      wb_rf_wb_i           = flags[0];
      fetch_rfb_adr_i      = vec_mem[base+2][4:0];
      decode_rfa_adr_i     = vec_mem[base+3][4:0];
      decode_rfb_adr_i     = vec_mem[base+4][4:0];
      execute_rfd_adr_i    = vec_mem[base+5][4:0];
      ctrl_rfd_adr_i       = vec_mem[base+6][4:0];
      wb_rfd_adr_i         = vec_mem[base+7][4:0];
      ctrl_alu_result_i    = vec_mem[base+8];
      result_i             = vec_mem[base+9];
   endtask

   task automatic idle_spr();
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
      spr_adr_i = '0;
      spr_dat_i = $random(seed);
   endtask

   task automatic check_pipeline(input int base);
      logic [2:0] mask;
      mask = vec_mem[base+10][2:0];
      if (mask[0]) check_operand("decode_rfb_o", decode_rfb_o, vec_mem[base+11]);
      if (mask[1]) check_operand("execute_rfa_o", execute_rfa_o, vec_mem[base+12]);
      if (mask[2]) check_operand("execute_rfb_o", execute_rfb_o, vec_mem[base+13]);
   endtask

   // writeback owns the port so the ack waits for the first cycle without one
   task automatic run_spr_write(input int base);
      int   cyc;
      int   expect_cyc;
      logic acked;
      cyc        = 0;
      acked      = 1'b0;
      expect_cyc = vec_mem[base+1][0] ? 1 : 0;
      spr_stb_i  = 1'b1;
      spr_we_i   = 1'b1;
      spr_adr_i  = gpr_spr_adr(vec_mem[base+14][4:0]);
      spr_dat_i  = vec_mem[base+15];
      while (!acked && cyc < SPR_WAIT) begin
         #18;
         if (spr_ack_o) begin
            if (wb_rf_wb_i) stop_with_failure("SPR write acknowledged during a writeback cycle");
            if (cyc != expect_cyc) begin
               stop_with_failure($sformatf("SPR write acknowledged in cycle %0d instead of %0d",
                                           cyc, expect_cyc));
            end
            acked = 1'b1;
         end else begin
            @(posedge clk);
            #2;
            drive_pipeline(base, 8'h00);
            cyc++;
         end
      end
      if (!acked) stop_with_failure("SPR write was not acknowledged within 20 cycles");
   endtask

   // padv_ctrl_i stays high for hold cycles before the two read cycles
   task automatic run_spr_read(input int base);
      int   cyc;
      int   hold;
      logic acked;
      cyc         = 0;
      acked       = 1'b0;
      hold        = int'(vec_mem[base+16]);
      spr_stb_i   = 1'b1;
      spr_we_i    = 1'b0;
      spr_adr_i   = gpr_spr_adr(vec_mem[base+14][4:0]);
      padv_ctrl_i = (hold > 0);
      while (!acked && cyc < SPR_WAIT) begin
         #18;
         if (spr_ack_o) begin
            if (padv_ctrl_i) stop_with_failure("SPR read acknowledged while ctrl advanced");
            if (cyc != hold + 1) begin
               stop_with_failure($sformatf("SPR read acknowledged in cycle %0d instead of %0d",
                                           cyc, hold + 1));
            end
            check_spr(spr_adr_i, vec_mem[base+15]);
            acked = 1'b1;
         end else begin
            @(posedge clk);
            #2;
            cyc++;
            padv_ctrl_i = (cyc < hold);
         end
      end
      if (!acked) stop_with_failure("SPR read was not acknowledged within 20 cycles");
   endtask

   initial begin
      int   rec;
      int   base;
      logic done;
      seed = 32'h2087;
      rst  = 1'b1;
      $readmemh("bench/rf_vectors.txt", vec_mem);
      drive_pipeline(0, 8'h00);
      idle_spr();
      repeat (10) @(posedge clk);
      #2;
      rst  = 1'b0;
      rec  = 0;
      done = 1'b0;
      while (!done && rec < MAX_RECS) begin
         base = rec * FIELDS;
         if (vec_mem[base] === 32'hf) begin
            done = 1'b1;
         end else begin
            @(posedge clk);
            #2;
            idle_spr();
            drive_pipeline(base, vec_mem[base+1][7:0]);
            case (vec_mem[base])
               32'h0: begin
                  #18;
                  check_pipeline(base);
               end
               32'h1: run_spr_write(base);
               32'h2: run_spr_read(base);
               default: stop_with_failure($sformatf("unknown vector operation in record %0d", rec));
            endcase
            rec++;
         end
      end
      if (!done) begin
         stop_with_failure("vector file has no end record");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// ==== bench/rf_vectors.txt ====
// op (0 pipe, 1 spr write, 2 spr read, f end) flags (padv_dec padv_ctrl flush dvalid fetch exe ctrl wb)
// fb da db ed cd wd alu result mask(1 drfb 2 rfa 4 rfb) exp_drfb exp_rfa exp_rfb spr_gpr spr_dat hold
0 11 00 00 00 00 00 01 0 11111111 0 0 0 0 00 0 0
0 11 00 00 00 00 00 02 0 22222222 0 0 0 0 00 0 0
0 11 00 00 00 00 00 03 0 33333333 0 0 0 0 00 0 0
0 11 00 00 00 00 00 04 0 44444444 0 0 0 0 00 0 0
0 11 00 00 00 00 00 05 0 55555555 0 0 0 0 00 0 0
0 18 02 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 90 02 01 02 00 00 00 0 0 1 22222222 0 0 00 0 0
0 10 00 00 00 00 00 00 0 0 6 0 11111111 22222222 00 0 0
0 18 02 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 94 02 01 02 01 00 00 0 0 1 22222222 0 0 00 0 0
0 10 00 00 00 00 00 00 AAAA0001 0 6 0 AAAA0001 22222222 00 0 0
0 18 02 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 97 02 01 02 01 01 02 0 BBBB0002 1 BBBB0002 0 0 00 0 0
0 10 00 00 00 00 00 00 CCCC0003 DDDD0004 6 0 CCCC0003 BBBB0002 00 0 0
0 18 04 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 93 04 03 04 00 03 03 0 EEEE0005 1 44444444 0 0 00 0 0
0 10 00 00 00 00 00 00 0 FFFF0006 6 0 FFFF0006 44444444 00 0 0
0 18 05 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 91 05 04 05 00 00 04 0 12340007 1 55555555 0 0 00 0 0
0 10 00 00 00 00 00 00 0 0 6 0 12340007 55555555 00 0 0
0 18 01 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 13 00 00 01 00 01 01 0A0A0A0A 0B0B0B0B 1 0A0A0A0A 0 0 00 0 0
0 11 00 00 01 00 00 01 0 0C0C0C0C 1 0C0C0C0C 0 0 00 0 0
0 10 00 00 01 00 00 00 0 0 1 0C0C0C0C 0 0 00 0 0
0 19 02 00 02 00 00 02 0 0D0D0D0D 0 0 0 0 00 0 0
0 10 00 00 02 00 00 00 0 0 1 0D0D0D0D 0 0 00 0 0
0 18 03 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 30 03 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 94 00 05 03 05 00 00 0 0 1 EEEE0005 0 0 00 0 0
0 10 00 00 00 00 00 00 99990009 0 6 0 55555555 EEEE0005 00 0 0
0 94 00 05 03 05 00 00 0 0 0 0 0 0 00 0 0
0 10 00 00 00 00 00 00 9999000A 0 2 0 9999000A 0 00 0 0
1 11 00 00 00 00 00 06 0 66666666 0 0 0 0 07 77777777 0
0 18 07 00 00 00 00 00 0 0 0 0 0 0 00 0 0
0 90 00 06 07 00 00 00 0 0 1 77777777 0 0 00 0 0
0 10 00 00 00 00 00 00 0 0 6 0 66666666 77777777 00 0 0
2 00 00 00 00 00 00 00 0 0 0 0 0 0 03 EEEE0005 3
2 00 00 00 00 00 00 00 0 0 0 0 0 0 07 77777777 0
2 00 00 00 00 00 00 00 0 0 0 0 0 0 01 0C0C0C0C 2
f

// ==== include/rf_defs.svh ====
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// data word carried by every register and result bus
`define RF_OPERAND_WIDTH 32

// register number and number of registers
`define RF_ADDR_WIDTH 5
`define RF_WORDS 32

// spr bus address word
`define SPR_ADDR_WIDTH 16

// page view of an spr address, top bits select the page
`define SPR_PAGE_WIDTH 7
`define SPR_GPR_PAGE 7'd2

// group view of an spr address, gpr page lives in the system group
`define SPR_GRP_WIDTH 5
`define SPR_SYS_GROUP 5'd0

`endif

// ==== rf_cappuccino.f ====
+incdir+include
rtl/rf_pkg.sv
rtl/spr_pkg.sv
rtl/rf_ram.sv
rtl/rf_write_arbiter.sv
rtl/rf_operand_bypass.sv
rtl/rf_cappuccino.sv
bench/rf_cappuccino_tb.sv

// ==== rtl/rf_cappuccino.sv ====
`timescale 1ns/1ps

module rf_cappuccino (
   input  logic               clk,
   input  logic               rst,

   // pipeline control
   input  logic               padv_decode_i,
   input  logic               padv_ctrl_i,
   input  logic               pipeline_flush_i,
   input  logic               decode_valid_i,
   input  logic               fetch_rf_adr_valid_i,

   // register numbers per stage
   input  rf_pkg::reg_adr_t   fetch_rfb_adr_i,
   input  rf_pkg::reg_adr_t   decode_rfa_adr_i,
   input  rf_pkg::reg_adr_t   decode_rfb_adr_i,
   input  rf_pkg::reg_adr_t   execute_rfd_adr_i,
   input  rf_pkg::reg_adr_t   ctrl_rfd_adr_i,
   input  rf_pkg::reg_adr_t   wb_rfd_adr_i,
   input  logic               execute_rf_wb_i,
   input  logic               ctrl_rf_wb_i,
   input  logic               wb_rf_wb_i,

   // stage results
   input  rf_pkg::operand_t   ctrl_alu_result_i,
   input  rf_pkg::operand_t   result_i,

   // spr bus
   input  logic               spr_stb_i,
   input  logic               spr_we_i,
   input  spr_pkg::spr_adr_u  spr_adr_i,
   input  rf_pkg::operand_t   spr_dat_i,
   output logic               spr_ack_o,
   output rf_pkg::operand_t   spr_dat_o,

   // operands
   output rf_pkg::operand_t   decode_rfb_o,
   output rf_pkg::operand_t   execute_rfa_o,
   output rf_pkg::operand_t   execute_rfb_o
);

   logic             wr_en;
   rf_pkg::reg_adr_t wr_adr;
   rf_pkg::operand_t wr_dat;
   rf_pkg::reg_adr_t spr_rd_adr;
   rf_pkg::operand_t rfa_ram_dat;
   rf_pkg::operand_t rfb_ram_dat;

   rf_write_arbiter u_arbiter (
      .clk          (clk),
      .rst          (rst),
      .spr_stb_i    (spr_stb_i),
      .spr_we_i     (spr_we_i),
      .spr_adr_i    (spr_adr_i),
      .spr_dat_i    (spr_dat_i),
      .padv_ctrl_i  (padv_ctrl_i),
      .wb_rf_wb_i   (wb_rf_wb_i),
      .wb_rfd_adr_i (wb_rfd_adr_i),
      .result_i     (result_i),
      .spr_ack_o    (spr_ack_o),
      .wr_en_o      (wr_en),
      .wr_adr_o     (wr_adr),
      .wr_dat_o     (wr_dat),
      .spr_rd_adr_o (spr_rd_adr)
   );

   // a operand copy, read as decode advances
   rf_ram rfa (
      .clk      (clk),
      .rst      (rst),
      .rd_adr_i (decode_rfa_adr_i),
      .rd_en_i  (padv_decode_i),
      .wr_adr_i (wr_adr),
      .wr_en_i  (wr_en),
      .wr_dat_i (wr_dat),
      .rd_dat_o (rfa_ram_dat)
   );

   // b operand copy, read from fetch
   rf_ram rfb (
      .clk      (clk),
      .rst      (rst),
      .rd_adr_i (fetch_rfb_adr_i),
      .rd_en_i  (fetch_rf_adr_valid_i),
      .wr_adr_i (wr_adr),
      .wr_en_i  (wr_en),
      .wr_dat_i (wr_dat),
      .rd_dat_o (rfb_ram_dat)
   );

   // debug copy for spr reads
   rf_ram rfspr (
      .clk      (clk),
      .rst      (rst),
      .rd_adr_i (spr_rd_adr),
      .rd_en_i  (1'b1),
      .wr_adr_i (wr_adr),
      .wr_en_i  (wr_en),
      .wr_dat_i (wr_dat),
      .rd_dat_o (spr_dat_o)
   );

   rf_operand_bypass u_bypass (
      .clk                  (clk),
      .rst                  (rst),
      .padv_decode_i        (padv_decode_i),
      .decode_valid_i       (decode_valid_i),
      .fetch_rf_adr_valid_i (fetch_rf_adr_valid_i),
      .pipeline_flush_i     (pipeline_flush_i),
      .fetch_rfb_adr_i      (fetch_rfb_adr_i),
      .decode_rfa_adr_i     (decode_rfa_adr_i),
      .decode_rfb_adr_i     (decode_rfb_adr_i),
      .execute_rfd_adr_i    (execute_rfd_adr_i),
      .ctrl_rfd_adr_i       (ctrl_rfd_adr_i),
      .wb_rfd_adr_i         (wb_rfd_adr_i),
      .execute_rf_wb_i      (execute_rf_wb_i),
      .ctrl_rf_wb_i         (ctrl_rf_wb_i),
      .wb_rf_wb_i           (wb_rf_wb_i),
      .result_i             (result_i),
      .ctrl_alu_result_i    (ctrl_alu_result_i),
      .rfa_ram_i            (rfa_ram_dat),
      .rfb_ram_i            (rfb_ram_dat),
      .decode_rfb_o         (decode_rfb_o),
      .execute_rfa_o        (execute_rfa_o),
      .execute_rfb_o        (execute_rfb_o)
   );

endmodule

// ==== rtl/rf_operand_bypass.sv ====
`timescale 1ns/1ps

module rf_operand_bypass (
   input  logic              clk,
   input  logic              rst,
   input  logic              padv_decode_i,
   input  logic              decode_valid_i,
   input  logic              fetch_rf_adr_valid_i,
   input  logic              pipeline_flush_i,
   input  rf_pkg::reg_adr_t  fetch_rfb_adr_i,
   input  rf_pkg::reg_adr_t  decode_rfa_adr_i,
   input  rf_pkg::reg_adr_t  decode_rfb_adr_i,
   input  rf_pkg::reg_adr_t  execute_rfd_adr_i,
   input  rf_pkg::reg_adr_t  ctrl_rfd_adr_i,
   input  rf_pkg::reg_adr_t  wb_rfd_adr_i,
   input  logic              execute_rf_wb_i,
   input  logic              ctrl_rf_wb_i,
   input  logic              wb_rf_wb_i,
   input  rf_pkg::operand_t  result_i,
   input  rf_pkg::operand_t  ctrl_alu_result_i,
   input  rf_pkg::operand_t  rfa_ram_i,
   input  rf_pkg::operand_t  rfb_ram_i,
   output rf_pkg::operand_t  decode_rfb_o,
   output rf_pkg::operand_t  execute_rfa_o,
   output rf_pkg::operand_t  execute_rfb_o
);

   logic flushing;

   logic execute_hazard_a;
   logic execute_hazard_b;
   logic ctrl_hazard_a;
   logic ctrl_hazard_b;
   logic wb_hazard_a;
   logic wb_hazard_b;

   rf_pkg::operand_t execute_hazard_result_r;
   rf_pkg::operand_t execute_hazard_result;
   rf_pkg::operand_t ctrl_hazard_result_r;
   rf_pkg::operand_t ctrl_hazard_result;
   rf_pkg::operand_t wb_hazard_result;
   rf_pkg::operand_t execute_rfb;

   logic             use_last_wb_b;
   logic             wb_to_decode_bypass_b;
   rf_pkg::operand_t wb_to_decode_result;
   logic             ctrl_to_decode_b;
   logic             wb_now_to_decode_b;

   // youngest matching stage wins over the ram or latched operand
   function automatic rf_pkg::operand_t pick_operand(
      input logic             exe_hz,
      input logic             ctrl_hz,
      input logic             wb_hz,
      input rf_pkg::operand_t fallback
   );
      if (exe_hz) begin
         return execute_hazard_result;
      end else if (ctrl_hz) begin
         return ctrl_hazard_result;
      end else if (wb_hz) begin
         return wb_hazard_result;
      end
      return fallback;
   endfunction

   // after a flush the execute stage holds no valid instruction until the
   // next decode advance, so its destination must not raise a hazard
   always_ff @(posedge clk) begin
      if (rst) begin
         flushing <= 1'b0;
      end else if (pipeline_flush_i) begin
         flushing <= 1'b1;
      end else if (padv_decode_i) begin
         flushing <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         execute_hazard_a <= 1'b0;
         execute_hazard_b <= 1'b0;
      end else if (padv_decode_i && !flushing) begin
         execute_hazard_a <= execute_rf_wb_i && (execute_rfd_adr_i == decode_rfa_adr_i);
         execute_hazard_b <= execute_rf_wb_i && (execute_rfd_adr_i == decode_rfb_adr_i);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_hazard_a <= 1'b0;
         ctrl_hazard_b <= 1'b0;
         wb_hazard_a   <= 1'b0;
         wb_hazard_b   <= 1'b0;
      end else if (padv_decode_i) begin
         ctrl_hazard_a <= ctrl_rf_wb_i && (ctrl_rfd_adr_i == decode_rfa_adr_i);
         ctrl_hazard_b <= ctrl_rf_wb_i && (ctrl_rfd_adr_i == decode_rfb_adr_i);
         wb_hazard_a   <= wb_rf_wb_i && (wb_rfd_adr_i == decode_rfa_adr_i);
         wb_hazard_b   <= wb_rf_wb_i && (wb_rfd_adr_i == decode_rfb_adr_i);
      end
   end

   // stage results follow the pipe while decode is valid and hold otherwise
   always_ff @(posedge clk) begin
      if (decode_valid_i) begin
         execute_hazard_result_r <= ctrl_alu_result_i;
         ctrl_hazard_result_r    <= result_i;
      end
   end

   assign execute_hazard_result = decode_valid_i ? ctrl_alu_result_i : execute_hazard_result_r;
   assign ctrl_hazard_result    = decode_valid_i ? result_i : ctrl_hazard_result_r;

   // writeback result leaves the pipe at the advance and is kept here
   always_ff @(posedge clk) begin
      if (padv_decode_i) begin
         wb_hazard_result <= result_i;
         execute_rfb      <= decode_rfb_o;
      end
   end

   // decode does not read the ram itself, so a writeback to the b source
   // between fetch and decode advance has to be saved here
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_to_decode_bypass_b <= 1'b0;
         use_last_wb_b         <= 1'b0;
      end else if (fetch_rf_adr_valid_i) begin
         wb_to_decode_bypass_b <= wb_rf_wb_i && (wb_rfd_adr_i == fetch_rfb_adr_i);
         use_last_wb_b         <= 1'b0;
      end else if (wb_now_to_decode_b) begin
         use_last_wb_b <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_rf_adr_valid_i || wb_now_to_decode_b) begin
         wb_to_decode_result <= result_i;
      end
   end

   assign ctrl_to_decode_b   = ctrl_rf_wb_i && (ctrl_rfd_adr_i == decode_rfb_adr_i);
   assign wb_now_to_decode_b = wb_rf_wb_i && (wb_rfd_adr_i == decode_rfb_adr_i);

   // only port b is needed in decode for jump-to-register
   always_comb begin
      if (ctrl_to_decode_b) begin
         decode_rfb_o = ctrl_alu_result_i;
      end else if (wb_now_to_decode_b) begin
         decode_rfb_o = result_i;
      end else if (use_last_wb_b || wb_to_decode_bypass_b) begin
         decode_rfb_o = wb_to_decode_result;
      end else begin
         decode_rfb_o = rfb_ram_i;
      end
   end

   always_comb begin
      execute_rfa_o = pick_operand(execute_hazard_a, ctrl_hazard_a, wb_hazard_a, rfa_ram_i);
      // b already went through the decode bypass and starts from the latched copy
      execute_rfb_o = pick_operand(execute_hazard_b, ctrl_hazard_b, wb_hazard_b, execute_rfb);
   end

   a_flags_known: assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown({flushing, execute_hazard_a, execute_hazard_b, ctrl_hazard_a,
                   ctrl_hazard_b, wb_hazard_a, wb_hazard_b,
                   use_last_wb_b, wb_to_decode_bypass_b})
   ) else $error("rf_operand_bypass: hazard flag unknown");

endmodule

// ==== rtl/rf_pkg.sv ====
`include "rf_defs.svh"

package rf_pkg;

   // value held by one general-purpose register
   typedef logic [`RF_OPERAND_WIDTH-1:0] operand_t;

   // register number
   typedef logic [`RF_ADDR_WIDTH-1:0] reg_adr_t;

endpackage

// ==== rtl/rf_ram.sv ====
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_ram (
   input  logic              clk,
   input  logic              rst,
   input  rf_pkg::reg_adr_t  rd_adr_i,
   input  logic              rd_en_i,
   input  rf_pkg::reg_adr_t  wr_adr_i,
   input  logic              wr_en_i,
   input  rf_pkg::operand_t  wr_dat_i,
   output rf_pkg::operand_t  rd_dat_o
);

   rf_pkg::operand_t mem [0:`RF_WORDS-1];

   // single write port
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end
   end

   // registered read, holds its value while the enable is low
   // a read in the same cycle as a write sees the old contents
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_dat_o <= mem[rd_adr_i];
      end
   end

   a_adr_known: assert property (
      @(posedge clk) disable iff (rst)
      (rd_en_i -> !$isunknown(rd_adr_i)) && (wr_en_i -> !$isunknown(wr_adr_i))
   ) else $error("rf_ram: unknown address with enable high");

endmodule

// ==== rtl/rf_write_arbiter.sv ====
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_write_arbiter (
   input  logic               clk,
   input  logic               rst,
   input  logic               spr_stb_i,
   input  logic               spr_we_i,
   input  spr_pkg::spr_adr_u  spr_adr_i,
   input  rf_pkg::operand_t   spr_dat_i,
   input  logic               padv_ctrl_i,
   input  logic               wb_rf_wb_i,
   input  rf_pkg::reg_adr_t   wb_rfd_adr_i,
   input  rf_pkg::operand_t   result_i,
   output logic               spr_ack_o,
   output logic               wr_en_o,
   output rf_pkg::reg_adr_t   wr_adr_o,
   output rf_pkg::operand_t   wr_dat_o,
   output rf_pkg::reg_adr_t   spr_rd_adr_o
);

   logic gpr_page_hit;
   logic spr_gpr_we;
   logic spr_gpr_re;
   logic read_ack_r;

   // strobe targets the gpr page
   assign gpr_page_hit = (spr_adr_i.gpr.page == `SPR_GPR_PAGE);

   assign spr_gpr_we = gpr_page_hit & spr_stb_i & spr_we_i;
   // reads hold off while ctrl advances
   assign spr_gpr_re = gpr_page_hit & spr_stb_i & ~spr_we_i & ~padv_ctrl_i;

   // armed by the first read cycle so that the second one acknowledges
   // cleared on the ack so a back-to-back read starts over
   always_ff @(posedge clk) begin
      if (rst) begin
         read_ack_r <= 1'b0;
      end else begin
         read_ack_r <= spr_gpr_re & ~spr_ack_o;
      end
   end

   assign spr_ack_o = (spr_gpr_we & ~wb_rf_wb_i) | (spr_gpr_re & read_ack_r);

   // writeback always owns the port when it writes
   assign wr_en_o  = wb_rf_wb_i | spr_gpr_we;
   assign wr_adr_o = wb_rf_wb_i ? wb_rfd_adr_i : spr_adr_i.gpr.gpr_num;
   assign wr_dat_o = wb_rf_wb_i ? result_i : spr_dat_i;

   // spr read copy of the ram looks at the bus address directly
   assign spr_rd_adr_o = spr_adr_i.gpr.gpr_num;

   a_ack_has_stb: assert property (
      @(posedge clk) disable iff (rst)
      spr_ack_o |-> spr_stb_i
   ) else $error("rf_write_arbiter: ack without strobe");

   a_no_wr_ack_in_wb: assert property (
      @(posedge clk) disable iff (rst)
      (spr_ack_o && spr_we_i) |-> !wb_rf_wb_i
   ) else $error("rf_write_arbiter: spr write acked during writeback");

   // a gpr page strobe keeps its group and register index until acknowledged
   a_stb_held: assert property (
      @(posedge clk) disable iff (rst)
      (gpr_page_hit && spr_stb_i && !spr_ack_o) |=>
         (spr_stb_i && $stable(spr_we_i) && $stable(spr_adr_i.grp.grp_num) &&
          $stable(spr_adr_i.grp.reg_idx))
   ) else $error("rf_write_arbiter: spr access changed before its ack");

endmodule

// ==== rtl/spr_pkg.sv ====
`include "rf_defs.svh"

package spr_pkg;

   // group view: unit group in the top bits, register index below
   typedef struct packed {
      logic [`SPR_GRP_WIDTH-1:0]                 grp_num;
      logic [`SPR_ADDR_WIDTH-`SPR_GRP_WIDTH-1:0] reg_idx;
   } spr_grp_s;

   // gpr view: page number, unused gap, then the register number
   typedef struct packed {
      logic [`SPR_PAGE_WIDTH-1:0]                                 page;
      logic [`SPR_ADDR_WIDTH-`SPR_PAGE_WIDTH-`RF_ADDR_WIDTH-1:0] rsvd;
      rf_pkg::reg_adr_t                                           gpr_num;
   } spr_gpr_s;

   // one address word, decoded either way
   typedef union packed {
      spr_grp_s grp;
      spr_gpr_s gpr;
   } spr_adr_u;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# builds the register file testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   -f rf_cappuccino.f \
   --top-module rf_cappuccino_tb \
   -o rf_cappuccino_sim

# the simulation exits non-zero on failure, the log search below decides
./obj_dir/rf_cappuccino_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
